// ==== src/mcu_params.svh ====
// mini MCU parameters
// memory depth, address map and peripheral register offsets

`ifndef MCU_PARAMS_SVH
`define MCU_PARAMS_SVH

// RAM depth in 32-bit words
`define MCU_RAM_WORDS 256

// address bit that selects the peripheral, base 0x2000_0000
`define MCU_PERIPH_SEL_BIT 29

// number of low address bits decoded inside the peripheral
`define MCU_REG_OFF_BITS 12

// peripheral register byte offsets
`define MCU_REG_EXIT       12'h000
`define MCU_REG_DMA_SRC    12'h004
`define MCU_REG_DMA_DST    12'h008
`define MCU_REG_DMA_LEN    12'h00C
`define MCU_REG_DMA_CTRL   12'h010
`define MCU_REG_DMA_STATUS 12'h014

// DMA status bits
`define MCU_STATUS_BUSY_BIT 0
`define MCU_STATUS_DONE_BIT 1

`endif

// ==== src/mcu_pkg.sv ====
// mini MCU shared types
// OBI request/response structs, DMA job descriptor and DMA states

package mcu_pkg;

  // widths with a meaning
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;
  typedef logic [15:0] len_t;

  // master to slave, 70 bits
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  // slave to master, 34 bits
  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } obi_resp_t;

  // one DMA job, 80 bits
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
  } dma_cfg_t;

  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    READ_REQ   = 3'd1,
    READ_WAIT  = 3'd2,
    WRITE_REQ  = 3'd3,
    WRITE_WAIT = 3'd4
  } dma_state_e;

endpackage

// ==== src/system_bus.sv ====
// system bus with two OBI masters and two slaves
// round-robin arbitration, address decode and response routing

`include "mcu_params.svh"

module system_bus (
  input  logic              clk_i,
  input  logic              rst_n_i,

  input  mcu_pkg::obi_req_t  host_req_i,
  output mcu_pkg::obi_resp_t host_resp_o,
  input  mcu_pkg::obi_req_t  dma_req_i,
  output mcu_pkg::obi_resp_t dma_resp_o,

  output mcu_pkg::obi_req_t  ram_req_o,
  input  mcu_pkg::obi_resp_t ram_resp_i,
  output mcu_pkg::obi_req_t  periph_req_o,
  input  mcu_pkg::obi_resp_t periph_resp_i
);

  logic              gnt_host;
  logic              gnt_dma;
  logic              any_gnt;
  logic              sel_dma;
  logic              to_periph;
  logic              slave_gnt;
  logic              handshake;
  logic              prio_q;
  logic              owner_q;
  logic              periph_q;
  logic              slave_rvalid;
  mcu_pkg::data_t    slave_rdata;
  mcu_pkg::obi_req_t fwd_req;

  // prio_q set means the DMA wins a tie
  assign gnt_host = host_req_i.req && (!dma_req_i.req || !prio_q);
  assign gnt_dma  = dma_req_i.req && (!host_req_i.req || prio_q);
  assign any_gnt  = gnt_host || gnt_dma;
  assign sel_dma  = gnt_dma;

  assign fwd_req   = sel_dma ? dma_req_i : host_req_i;
  assign to_periph = fwd_req.addr[`MCU_PERIPH_SEL_BIT];

  always_comb begin
    ram_req_o        = fwd_req;
    ram_req_o.req    = any_gnt && !to_periph;
    periph_req_o     = fwd_req;
    periph_req_o.req = any_gnt && to_periph;
  end

  assign slave_gnt = to_periph ? periph_resp_i.gnt : ram_resp_i.gnt;
  assign handshake = any_gnt && slave_gnt;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_q   <= 1'b0;
      owner_q  <= 1'b0;
      periph_q <= 1'b0;
    end else if (handshake) begin
      owner_q  <= sel_dma;
      periph_q <= to_periph;
      // hand the tie to the master that just lost
      if (host_req_i.req && dma_req_i.req) begin
        prio_q <= !sel_dma;
      end
    end
  end

  // data phase follows the owner of the last handshake
  assign slave_rvalid = periph_q ? periph_resp_i.rvalid : ram_resp_i.rvalid;
  assign slave_rdata  = periph_q ? periph_resp_i.rdata : ram_resp_i.rdata;

  always_comb begin
    host_resp_o.gnt    = gnt_host && slave_gnt;
    host_resp_o.rvalid = slave_rvalid && !owner_q;
    host_resp_o.rdata  = slave_rdata;
    dma_resp_o.gnt     = gnt_dma && slave_gnt;
    dma_resp_o.rvalid  = slave_rvalid && owner_q;
    dma_resp_o.rdata   = slave_rdata;
  end

  a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (host_resp_o.gnt |-> host_req_i.req) and (dma_resp_o.gnt |-> dma_req_i.req));

  a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(host_resp_o.gnt && dma_resp_o.gnt));

  a_host_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_resp_o.rvalid |-> $past(host_resp_o.gnt));

  a_dma_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dma_resp_o.rvalid |-> $past(dma_resp_o.gnt));

endmodule

// ==== src/sram_bank.sv ====
// single-port SRAM bank on the OBI bus
// byte-enable writes, registered read data one cycle after grant

`include "mcu_params.svh"

module sram_bank (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  mcu_pkg::obi_req_t  req_i,
  output mcu_pkg::obi_resp_t resp_o
);

  localparam int AW = $clog2(`MCU_RAM_WORDS);

  mcu_pkg::data_t mem [`MCU_RAM_WORDS];
  mcu_pkg::data_t rdata_q;
  logic           rvalid_q;
  logic [AW-1:0]  idx;

  // word index, upper bits alias
  assign idx = req_i.addr[AW+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.be[b]) begin
            mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.rdata  = rdata_q;

endmodule

// ==== src/dma_engine.sv ====
// single-channel DMA engine
// copies len words from src to dst, one read then one write per word

module dma_engine (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  mcu_pkg::dma_cfg_t  cfg_i,
  input  logic               start_i,
  output logic               busy_o,
  output logic               done_o,
  output mcu_pkg::obi_req_t  bus_req_o,
  input  mcu_pkg::obi_resp_t bus_resp_i
);

  mcu_pkg::dma_state_e state_q;
  mcu_pkg::addr_t      src_q;
  mcu_pkg::addr_t      dst_q;
  mcu_pkg::len_t       cnt_q;
  mcu_pkg::data_t      data_q;
  logic                done_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= mcu_pkg::IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        mcu_pkg::IDLE: begin
          if (start_i) begin
            if (cfg_i.len == '0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= mcu_pkg::READ_REQ;
            end
          end
        end
        mcu_pkg::READ_REQ: begin
          if (bus_resp_i.gnt) state_q <= mcu_pkg::READ_WAIT;
        end
        mcu_pkg::READ_WAIT: begin
          if (bus_resp_i.rvalid) state_q <= mcu_pkg::WRITE_REQ;
        end
        mcu_pkg::WRITE_REQ: begin
          if (bus_resp_i.gnt) state_q <= mcu_pkg::WRITE_WAIT;
        end
        mcu_pkg::WRITE_WAIT: begin
          if (bus_resp_i.rvalid) begin
            if (cnt_q == mcu_pkg::len_t'(1)) begin
              state_q <= mcu_pkg::IDLE;
              done_q  <= 1'b1;
            end else begin
              state_q <= mcu_pkg::READ_REQ;
            end
          end
        end
        default: state_q <= mcu_pkg::IDLE;
      endcase
    end
  end

  // job registers, only meaningful while busy
  always_ff @(posedge clk_i) begin
    if (state_q == mcu_pkg::IDLE && start_i) begin
      src_q <= cfg_i.src;
      dst_q <= cfg_i.dst;
      cnt_q <= cfg_i.len;
    end else if (state_q == mcu_pkg::WRITE_WAIT && bus_resp_i.rvalid) begin
      src_q <= src_q + 32'd4;
      dst_q <= dst_q + 32'd4;
      cnt_q <= cnt_q - mcu_pkg::len_t'(1);
    end
    if (state_q == mcu_pkg::READ_WAIT && bus_resp_i.rvalid) begin
      data_q <= bus_resp_i.rdata;
    end
  end

  always_comb begin
    bus_req_o.req   = (state_q == mcu_pkg::READ_REQ) || (state_q == mcu_pkg::WRITE_REQ);
    bus_req_o.we    = (state_q == mcu_pkg::WRITE_REQ);
    bus_req_o.be    = 4'hF;
    bus_req_o.addr  = bus_req_o.we ? dst_q : src_q;
    bus_req_o.wdata = data_q;
  end

  assign busy_o = (state_q != mcu_pkg::IDLE);
  assign done_o = done_q;

  a_rvalid_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_resp_i.rvalid |-> (state_q == mcu_pkg::READ_WAIT || state_q == mcu_pkg::WRITE_WAIT));

endmodule

// ==== src/ao_peripheral.sv ====
// always-on peripheral registers
// exit value/valid, DMA job setup, start pulse and sticky done status

`include "mcu_params.svh"

module ao_peripheral (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  mcu_pkg::obi_req_t  req_i,
  output mcu_pkg::obi_resp_t resp_o,
  output mcu_pkg::dma_cfg_t  dma_cfg_o,
  output logic               dma_start_o,
  input  logic               dma_busy_i,
  input  logic               dma_done_i,
  output mcu_pkg::data_t     exit_value_o,
  output logic               exit_valid_o,
  output logic               dma_intr_o
);

  logic [`MCU_REG_OFF_BITS-1:0] reg_off;
  logic                         wr;
  logic                         rd;
  mcu_pkg::data_t               rdata_d;
  mcu_pkg::data_t               rdata_q;
  logic                         rvalid_q;
  mcu_pkg::data_t               exit_value_q;
  logic                         exit_valid_q;
  mcu_pkg::dma_cfg_t            cfg_q;
  logic                         start_q;
  logic                         done_q;

  assign reg_off = req_i.addr[`MCU_REG_OFF_BITS-1:0];
  assign wr      = req_i.req && req_i.we;
  assign rd      = req_i.req && !req_i.we;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      cfg_q        <= '0;
      start_q      <= 1'b0;
      done_q       <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      start_q  <= wr && (reg_off == `MCU_REG_DMA_CTRL) && req_i.wdata[0];
      if (wr) begin
        case (reg_off)
          `MCU_REG_EXIT: begin
            exit_value_q <= req_i.wdata;
            exit_valid_q <= 1'b1;
          end
          `MCU_REG_DMA_SRC:    cfg_q.src <= req_i.wdata;
          `MCU_REG_DMA_DST:    cfg_q.dst <= req_i.wdata;
          `MCU_REG_DMA_LEN:    cfg_q.len <= req_i.wdata[15:0];
          `MCU_REG_DMA_STATUS: done_q    <= 1'b0;
          default: ;
        endcase
      end
      // a new completion wins over a clear in the same cycle
      if (dma_done_i) done_q <= 1'b1;
    end
  end

  always_comb begin
    rdata_d = '0;
    case (reg_off)
      `MCU_REG_EXIT:    rdata_d = exit_value_q;
      `MCU_REG_DMA_SRC: rdata_d = cfg_q.src;
      `MCU_REG_DMA_DST: rdata_d = cfg_q.dst;
      `MCU_REG_DMA_LEN: rdata_d = {16'h0, cfg_q.len};
      `MCU_REG_DMA_STATUS: begin
        rdata_d[`MCU_STATUS_BUSY_BIT] = dma_busy_i;
        rdata_d[`MCU_STATUS_DONE_BIT] = done_q;
      end
      default: rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd) rdata_q <= rdata_d;
  end

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.rdata  = rdata_q;

  assign dma_cfg_o    = cfg_q;
  assign dma_start_o  = start_q;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;
  assign dma_intr_o   = done_q;

endmodule

// ==== src/mini_mcu.sv ====
// mini MCU top level
// host port and DMA share the system bus to the SRAM and peripheral

module mini_mcu (
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  mcu_pkg::obi_req_t  host_req_i,
  output mcu_pkg::obi_resp_t host_resp_o,

  output mcu_pkg::data_t     exit_value_o,
  output logic               exit_valid_o,
  output logic               dma_intr_o
);

  // DMA master
  mcu_pkg::obi_req_t  dma_req;
  mcu_pkg::obi_resp_t dma_resp;

  // slaves
  mcu_pkg::obi_req_t  ram_req;
  mcu_pkg::obi_resp_t ram_resp;
  mcu_pkg::obi_req_t  periph_req;
  mcu_pkg::obi_resp_t periph_resp;

  // DMA control
  mcu_pkg::dma_cfg_t  dma_cfg;
  logic               dma_start;
  logic               dma_busy;
  logic               dma_done;

  system_bus u_system_bus (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .host_req_i   (host_req_i),
    .host_resp_o  (host_resp_o),
    .dma_req_i    (dma_req),
    .dma_resp_o   (dma_resp),
    .ram_req_o    (ram_req),
    .ram_resp_i   (ram_resp),
    .periph_req_o (periph_req),
    .periph_resp_i(periph_resp)
  );

  sram_bank u_sram_bank (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (ram_req),
    .resp_o (ram_resp)
  );

  ao_peripheral u_ao_peripheral (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (periph_req),
    .resp_o      (periph_resp),
    .dma_cfg_o   (dma_cfg),
    .dma_start_o (dma_start),
    .dma_busy_i  (dma_busy),
    .dma_done_i  (dma_done),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o),
    .dma_intr_o  (dma_intr_o)
  );

  dma_engine u_dma_engine (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .cfg_i     (dma_cfg),
    .start_i   (dma_start),
    .busy_o    (dma_busy),
    .done_o    (dma_done),
    .bus_req_o (dma_req),
    .bus_resp_i(dma_resp)
  );

endmodule

// ==== tb/tb_mini_mcu.sv ====
// testbench for the mini MCU
// host bus transactions from an operation table, DMA copy and contention checks

`include "mcu_params.svh"

module tb_mini_mcu;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 50;
  localparam int POLL_LIMIT = 200;
  localparam mcu_pkg::addr_t PERIPH_BASE = mcu_pkg::addr_t'(1) << `MCU_PERIPH_SEL_BIT;

  // one host bus operation
  typedef struct packed {
    logic           we;
    mcu_pkg::be_t   be;
    mcu_pkg::addr_t addr;
    mcu_pkg::data_t wdata;
    mcu_pkg::data_t exp;
  } op_t;

  logic               clk;
  logic               rst_n;
  mcu_pkg::obi_req_t  host_req;
  mcu_pkg::obi_resp_t host_resp;
  mcu_pkg::data_t     exit_value;
  logic               exit_valid;
  logic               dma_intr;

  op_t            ops[$];
  string          names[$];
  mcu_pkg::data_t ram_model [`MCU_RAM_WORDS];
  mcu_pkg::data_t rng_state;
  int             tests_run;
  int             tests_failed;

  mini_mcu u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .host_req_i  (host_req),
    .host_resp_o (host_resp),
    .exit_value_o(exit_value),
    .exit_valid_o(exit_valid),
    .dma_intr_o  (dma_intr)
  );

  always #5 clk = ~clk;

  function automatic mcu_pkg::data_t xorshift32(input mcu_pkg::data_t x);
    mcu_pkg::data_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic mcu_pkg::addr_t reg_addr(input logic [11:0] off);
    return {PERIPH_BASE[31:12], off};
  endfunction

  function automatic int ram_index(input mcu_pkg::addr_t a);
    return int'((a >> 2) % `MCU_RAM_WORDS);
  endfunction

  task automatic next_rand(output mcu_pkg::data_t r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  task automatic report_result(input string name, input bit ok);
    tests_run++;
    if (ok) begin
      $display("PASS  %s", name);
    end else begin
      tests_failed++;
      $display("FAIL  %s", name);
    end
  endtask

  task automatic check_value(input string name, input mcu_pkg::data_t exp,
                             input mcu_pkg::data_t act);
    if (act !== exp) begin
      $display("** Error: %s expected %h actual %h", name, exp, act);
    end
    report_result(name, act === exp);
  endtask

  // writes to RAM also update the model byte by byte
  task automatic add_write(input string name, input mcu_pkg::addr_t addr,
                           input mcu_pkg::data_t wdata, input mcu_pkg::be_t be);
    op_t op;
    int  k;
    op.we    = 1'b1;
    op.be    = be;
    op.addr  = addr;
    op.wdata = wdata;
    op.exp   = '0;
    ops.push_back(op);
    names.push_back(name);
    if (!addr[`MCU_PERIPH_SEL_BIT]) begin
      k = ram_index(addr);
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          ram_model[k][8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end
  endtask

  task automatic add_read(input string name, input mcu_pkg::addr_t addr,
                          input mcu_pkg::data_t exp);
    op_t op;
    op.we    = 1'b0;
    op.be    = 4'hF;
    op.addr  = addr;
    op.wdata = '0;
    op.exp   = exp;
    ops.push_back(op);
    names.push_back(name);
  endtask

  // st is 0 on a response, 1 without a grant and 2 without rvalid
  // lat counts cycles from the grant to rvalid
  task automatic bus_access(input op_t op, output mcu_pkg::data_t rdata,
                            output int st, output int lat);
    mcu_pkg::obi_req_t r;
    int                waited;
    logic              got_gnt;
    r.req   = 1'b1;
    r.we    = op.we;
    r.be    = op.be;
    r.addr  = op.addr;
    r.wdata = op.wdata;
    rdata   = '0;
    st      = 0;
    lat     = 0;
    @(posedge clk);
    host_req <= r;
    waited = 0;
    @(negedge clk);
    while (!host_resp.gnt && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    got_gnt = host_resp.gnt;
    @(posedge clk);
    host_req <= '0;
    if (!got_gnt) begin
      st = 1;
      return;
    end
    waited = 0;
    @(negedge clk);
    while (!host_resp.rvalid && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!host_resp.rvalid) begin
      st = 2;
    end else begin
      rdata = host_resp.rdata;
      lat   = waited + 1;
    end
  endtask

  task automatic run_table();
    mcu_pkg::data_t rd;
    int             st;
    int             lat;
    bit             ok;
    foreach (ops[k]) begin
      bus_access(ops[k], rd, st, lat);
      ok = 1'b1;
      if (st == 1) begin
        $display("%s: the host request was never granted", names[k]);
        ok = 1'b0;
      end
      if (st == 2) begin
        $display("%s: no response arrived after the grant", names[k]);
        ok = 1'b0;
      end
      if (st == 0 && lat != 1) begin
        $display("** Error: %s rvalid latency expected 1 actual %0d", names[k], lat);
        ok = 1'b0;
      end
      if (st == 0 && !ops[k].we && rd !== ops[k].exp) begin
        $display("** Error: %s expected %h actual %h", names[k], ops[k].exp, rd);
        ok = 1'b0;
      end
      report_result(names[k], ok);
    end
    ops.delete();
    names.delete();
  endtask

  task automatic wait_dma_done(input string name);
    op_t            op;
    mcu_pkg::data_t rd;
    int             st;
    int             lat;
    int             polls;
    logic           done;
    op.we    = 1'b0;
    op.be    = 4'hF;
    op.addr  = reg_addr(`MCU_REG_DMA_STATUS);
    op.wdata = '0;
    op.exp   = '0;
    done  = 1'b0;
    polls = 0;
    while (!done && polls < POLL_LIMIT) begin
      bus_access(op, rd, st, lat);
      done = (st == 0) && rd[`MCU_STATUS_DONE_BIT];
      polls++;
    end
    if (!done) begin
      $display("%s: the DMA did not report done within %0d status polls", name, POLL_LIMIT);
    end
    report_result(name, done);
  endtask

  task automatic start_dma(input string name, input mcu_pkg::addr_t src,
                           input mcu_pkg::addr_t dst, input int len);
    add_write({name, " src"}, reg_addr(`MCU_REG_DMA_SRC), src, 4'hF);
    add_write({name, " dst"}, reg_addr(`MCU_REG_DMA_DST), dst, 4'hF);
    add_write({name, " len"}, reg_addr(`MCU_REG_DMA_LEN), mcu_pkg::data_t'(len), 4'hF);
    add_read({name, " len readback"}, reg_addr(`MCU_REG_DMA_LEN), mcu_pkg::data_t'(len));
    add_write({name, " start"}, reg_addr(`MCU_REG_DMA_CTRL), 32'd1, 4'hF);
    run_table();
  endtask

  // expected copy result, then read back chk destination words and clear done
  task automatic verify_copy(input string name, input mcu_pkg::addr_t src,
                             input mcu_pkg::addr_t dst, input int len,
                             input int chk);
    mcu_pkg::addr_t a;
    wait_dma_done({name, " done"});
    check_value({name, " intr set"}, 32'd1, mcu_pkg::data_t'(dma_intr));
    for (int i = 0; i < len; i++) begin
      ram_model[ram_index(dst) + i] = ram_model[ram_index(src) + i];
    end
    add_read({name, " status done"}, reg_addr(`MCU_REG_DMA_STATUS), 32'd2);
    for (int i = 0; i < chk; i++) begin
      a = mcu_pkg::addr_t'(dst + 4 * i);
      add_read($sformatf("%s dst %0d", name, i), a, ram_model[ram_index(a)]);
    end
    add_write({name, " status clear"}, reg_addr(`MCU_REG_DMA_STATUS), 32'd0, 4'hF);
    add_read({name, " status cleared"}, reg_addr(`MCU_REG_DMA_STATUS), 32'd0);
    run_table();
    check_value({name, " intr clear"}, 32'd0, mcu_pkg::data_t'(dma_intr));
  endtask

  initial begin
    mcu_pkg::data_t w;
    mcu_pkg::addr_t a;
    clk          = 1'b0;
    rst_n        = 1'b0;
    host_req     = '0;
    rng_state    = 32'd19701;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    check_value("reset exit_valid", 32'd0, mcu_pkg::data_t'(exit_valid));
    check_value("reset exit_value", 32'd0, exit_value);
    check_value("reset dma_intr", 32'd0, mcu_pkg::data_t'(dma_intr));
    add_read("reset status", reg_addr(`MCU_REG_DMA_STATUS), 32'd0);
    run_table();

    // random words, then a partial write and an aliased address
    for (int i = 0; i < 8; i++) begin
      next_rand(w);
      add_write($sformatf("ram write %0d", i), mcu_pkg::addr_t'(4 * i), w, 4'hF);
    end
    for (int i = 0; i < 8; i++) begin
      add_read($sformatf("ram read %0d", i), mcu_pkg::addr_t'(4 * i), ram_model[i]);
    end
    add_write("byte enable base", 32'h20, 32'h1122_3344, 4'hF);
    add_write("byte enable partial", 32'h20, 32'hAABB_CCDD, 4'b0101);
    add_read("byte enable read", 32'h20, 32'h11BB_33DD);
    add_write("alias write", mcu_pkg::addr_t'((`MCU_RAM_WORDS + 9) * 4), 32'hCAFE_F00D, 4'hF);
    add_read("alias read", 32'h24, 32'hCAFE_F00D);
    add_write("exit write", reg_addr(`MCU_REG_EXIT), 32'h0000_002A, 4'hF);
    add_read("exit readback", reg_addr(`MCU_REG_EXIT), 32'h0000_002A);
    add_read("undefined offset", reg_addr(12'h100), 32'd0);
    run_table();
    check_value("exit_valid set", 32'd1, mcu_pkg::data_t'(exit_valid));
    check_value("exit_value", 32'h0000_002A, exit_value);

    // plain copy of 16 words
    for (int i = 0; i < 16; i++) begin
      next_rand(w);
      add_write($sformatf("dma source %0d", i), mcu_pkg::addr_t'(32'h100 + 4 * i), w, 4'hF);
    end
    run_table();
    start_dma("dma copy", 32'h100, 32'h200, 16);
    verify_copy("dma copy", 32'h100, 32'h200, 16, 16);

    // zero length must leave the destination alone
    start_dma("dma len0", 32'h100, 32'h000, 0);
    verify_copy("dma len0", 32'h100, 32'h000, 0, 4);

    // host traffic on another region while the DMA runs
    for (int i = 0; i < 16; i++) begin
      next_rand(w);
      add_write($sformatf("busy source %0d", i), mcu_pkg::addr_t'(32'h300 + 4 * i), w, 4'hF);
    end
    run_table();
    start_dma("dma busy", 32'h300, 32'h380, 16);
    for (int i = 0; i < 8; i++) begin
      next_rand(w);
      a = mcu_pkg::addr_t'(32'h280 + 4 * i);
      add_write($sformatf("contention write %0d", i), a, w, 4'hF);
      add_read($sformatf("contention read %0d", i), a, ram_model[ram_index(a)]);
    end
    // copy of 16 words needs at least 64 cycles, so it is still running here
    add_read("contention busy status", reg_addr(`MCU_REG_DMA_STATUS), 32'd1);
    run_table();
    verify_copy("dma busy", 32'h300, 32'h380, 16, 16);

    $display("tests run: %0d, failed: %0d", tests_run, tests_failed);
    if (tests_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+src
src/mcu_pkg.sv
src/system_bus.sv
src/sram_bank.sv
src/dma_engine.sv
src/ao_peripheral.sv
src/mini_mcu.sv
tb/tb_mini_mcu.sv

// ==== Makefile ====
# Verilator build and run for the mini MCU testbench

TOP = tb_mini_mcu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f vlog.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		-f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
